//--- common/muldiv_defines.svh
`ifndef MULDIV_DEFINES_SVH
`define MULDIV_DEFINES_SVH

// datapath width and divider length
`define MD_XLEN      32
`define MD_DIV_ITER  `MD_XLEN   // one quotient bit per iteration

// alu operation codes seen by the muldiv block
`define MD_OP_W      5
`define MD_OP_NOP    5'h00
`define MD_OP_MULT   5'h01   // signed 64-bit product
`define MD_OP_MULTU  5'h02
`define MD_OP_DIV    5'h03   // lo = quotient, hi = remainder
`define MD_OP_DIVU   5'h04
`define MD_OP_MTHI   5'h05
`define MD_OP_MTLO   5'h06
`define MD_OP_MFHI   5'h07   // read back through hilo_rdata
`define MD_OP_MFLO   5'h08

`endif

//--- common/muldiv_pkg.sv
`include "muldiv_defines.svh"

package muldiv_pkg;

   // operation code as presented by the pipeline
   typedef logic [`MD_OP_W-1:0] alu_op_t;

   // hi/lo pair, used for products and for quotient/remainder
   typedef struct packed {
      logic [`MD_XLEN-1:0] hi;
      logic [`MD_XLEN-1:0] lo;
   } hilo_result_t;

   // divide request handed to the divider
   typedef struct packed {
      logic                is_signed;
      logic [`MD_XLEN-1:0] dividend;
      logic [`MD_XLEN-1:0] divisor;
   } div_req_t;

   // divide sequencing in the execute stage
   typedef enum logic [1:0] {
      IDLE,    // single-cycle ops, or latch divide operands
      ISSUE,   // start pulse to divider
      WAIT     // divider running
   } md_state_t;

endpackage

//--- hw/exe_muldiv_top.sv
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module exe_muldiv_top (
   input  logic                aclk,
   input  logic                rst,
   input  muldiv_pkg::alu_op_t alu_op,
   input  logic [`MD_XLEN-1:0] operand_a,
   input  logic [`MD_XLEN-1:0] operand_b,
   output logic                stall,
   output logic                finish,
   output logic [`MD_XLEN-1:0] hilo_rdata
);

   import muldiv_pkg::*;

   logic         div_start;
   logic         div_done;
   div_req_t     div_req;
   hilo_result_t div_result;   // hi = remainder, lo = quotient
   logic         res_we;
   hilo_result_t res;

   muldiv_unit u_unit (
      .aclk       (aclk),
      .rst        (rst),
      .alu_op     (alu_op),
      .operand_a  (operand_a),
      .operand_b  (operand_b),
      .stall      (stall),
      .finish     (finish),
      .res_we     (res_we),
      .res        (res),
      .div_start  (div_start),
      .div_req    (div_req),
      .div_done   (div_done),
      .div_result (div_result)
   );

   radix2_divider u_div (
      .aclk       (aclk),
      .rst        (rst),
      .div_start  (div_start),
      .div_req    (div_req),
      .div_done   (div_done),
      .div_result (div_result),
      .div_busy   ()
   );

   hilo_regs u_hilo (
      .aclk       (aclk),
      .rst        (rst),
      .alu_op     (alu_op),
      .operand_a  (operand_a),
      .res_we     (res_we),
      .res        (res),
      .hilo_rdata (hilo_rdata)
   );

endmodule

//--- hw/hilo_regs.sv
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module hilo_regs (
   input  logic                     aclk,
   input  logic                     rst,
   input  muldiv_pkg::alu_op_t      alu_op,
   input  logic [`MD_XLEN-1:0]      operand_a,
   input  logic                     res_we,
   input  muldiv_pkg::hilo_result_t res,
   output logic [`MD_XLEN-1:0]      hilo_rdata
);

   logic [`MD_XLEN-1:0] hi;
   logic [`MD_XLEN-1:0] lo;

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         hi <= '0;
         lo <= '0;
      end else if (res_we) begin
         hi <= res.hi;   // mult product or div remainder
         lo <= res.lo;
      end else if (alu_op == `MD_OP_MTHI) begin
         hi <= operand_a;
      end else if (alu_op == `MD_OP_MTLO) begin
         lo <= operand_a;
      end
   end

   // move-from read, same cycle
   always_comb begin
      case (alu_op)
         `MD_OP_MFHI: hilo_rdata = hi;
         `MD_OP_MFLO: hilo_rdata = lo;
         default:     hilo_rdata = '0;
      endcase
   end

endmodule

//--- muldiv/muldiv_unit.sv
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module muldiv_unit (
   input  logic                     aclk,
   input  logic                     rst,
   input  muldiv_pkg::alu_op_t      alu_op,
   input  logic [`MD_XLEN-1:0]      operand_a,
   input  logic [`MD_XLEN-1:0]      operand_b,
   output logic                     stall,
   output logic                     finish,
   output logic                     res_we,
   output muldiv_pkg::hilo_result_t res,
   output logic                     div_start,
   output muldiv_pkg::div_req_t     div_req,
   input  logic                     div_done,
   input  muldiv_pkg::hilo_result_t div_result
);

   import muldiv_pkg::*;

   md_state_t             state;
   md_state_t             next_state;
   logic                  is_mul;
   logic                  is_div;
   logic                  div_fin;
   logic [`MD_XLEN:0]     a_ext;    // 33 bits, sign or zero extended
   logic [`MD_XLEN:0]     b_ext;
   logic [2*`MD_XLEN-1:0] prod;
   hilo_result_t          prod_res;

   assign is_mul = (alu_op == `MD_OP_MULT) || (alu_op == `MD_OP_MULTU);
   assign is_div = (alu_op == `MD_OP_DIV) || (alu_op == `MD_OP_DIVU);

   // single-cycle multiplier
   // one extra bit turns both MULT and MULTU into a signed multiply
   always_comb begin
      if (alu_op == `MD_OP_MULT) begin
         a_ext = {operand_a[`MD_XLEN-1], operand_a};
         b_ext = {operand_b[`MD_XLEN-1], operand_b};
      end else begin
         a_ext = {1'b0, operand_a};
         b_ext = {1'b0, operand_b};
      end
   end

   assign prod        = $signed(a_ext) * $signed(b_ext);   // 64 bits always hold the result
   assign prod_res.hi = prod[2*`MD_XLEN-1:`MD_XLEN];
   assign prod_res.lo = prod[`MD_XLEN-1:0];

   // divide sequencing
   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         state <= IDLE;
      end else begin
         state <= next_state;
      end
   end

   always_comb begin
      next_state = state;
      case (state)
         IDLE: begin
            if (is_div) begin
               next_state = ISSUE;
            end
         end
         ISSUE: next_state = WAIT;
         WAIT: begin
            if (div_done) begin
               next_state = IDLE;   // result written this cycle
            end
         end
         default: next_state = IDLE;
      endcase
   end

   // operand latch, taken in the first divide cycle
   always_ff @(posedge aclk) begin
      if (state == IDLE && is_div) begin
         div_req.is_signed <= (alu_op == `MD_OP_DIV);
         div_req.dividend  <= operand_a;
         div_req.divisor   <= operand_b;
      end
   end

   assign div_start = (state == ISSUE);
   assign div_fin   = (state == WAIT) && div_done;

   // hold the pipeline from the first divide cycle up to div_done
   assign stall = ((state == IDLE) && is_div) ||
                  (state == ISSUE) ||
                  ((state == WAIT) && !div_done);

   assign finish = is_mul || div_fin;
   assign res_we = finish;                              // hi/lo load strobe
   assign res    = div_fin ? div_result : prod_res;

endmodule

//--- muldiv/radix2_divider.sv
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module radix2_divider (
   input  logic                     aclk,
   input  logic                     rst,
   input  logic                     div_start,
   input  muldiv_pkg::div_req_t     div_req,
   output logic                     div_done,
   output muldiv_pkg::hilo_result_t div_result,
   output logic                     div_busy
);

   localparam int CNT_W = $clog2(`MD_DIV_ITER);

   logic                busy;       // shift-subtract steps running
   logic                fix;        // final cycle, sign correction
   logic [CNT_W-1:0]    count;
   logic [`MD_XLEN:0]   rem;        // partial remainder
   logic [`MD_XLEN-1:0] quo;        // dividend shifts out, quotient shifts in
   logic [`MD_XLEN-1:0] dvsr;
   logic                neg_q;
   logic                neg_r;
   logic [`MD_XLEN-1:0] dividend_mag;
   logic [`MD_XLEN-1:0] divisor_mag;
   logic [`MD_XLEN+1:0] rem_shift;
   logic [`MD_XLEN+1:0] trial;
   logic                accept;

   assign accept = div_start && !busy;

   // magnitudes for the signed case
   assign dividend_mag = (div_req.is_signed && div_req.dividend[`MD_XLEN-1]) ?
                         -div_req.dividend : div_req.dividend;
   assign divisor_mag  = (div_req.is_signed && div_req.divisor[`MD_XLEN-1]) ?
                         -div_req.divisor : div_req.divisor;

   // one restoring step
   assign rem_shift = {rem, quo[`MD_XLEN-1]};
   assign trial     = rem_shift - {2'b00, dvsr};   // msb set means borrow

   always_ff @(posedge aclk or negedge rst) begin
      if (!rst) begin
         busy  <= 1'b0;
         fix   <= 1'b0;
         count <= '0;
      end else begin
         fix <= 1'b0;
         if (accept) begin
            busy  <= 1'b1;
            count <= '0;
         end else if (busy) begin
            count <= count + 1'b1;
            if (count == CNT_W'(`MD_DIV_ITER - 1)) begin
               busy <= 1'b0;
               fix  <= 1'b1;   // last bit done, result out next cycle
            end
         end
      end
   end

   always_ff @(posedge aclk) begin
      if (accept) begin
         rem   <= '0;
         quo   <= dividend_mag;
         dvsr  <= divisor_mag;
         neg_q <= div_req.is_signed &&
                  (div_req.dividend[`MD_XLEN-1] ^ div_req.divisor[`MD_XLEN-1]);
         neg_r <= div_req.is_signed && div_req.dividend[`MD_XLEN-1];
      end else if (busy) begin
         if (trial[`MD_XLEN+1]) begin
            rem <= rem_shift[`MD_XLEN:0];   // restore
            quo <= {quo[`MD_XLEN-2:0], 1'b0};
         end else begin
            rem <= trial[`MD_XLEN:0];
            quo <= {quo[`MD_XLEN-2:0], 1'b1};
         end
      end
   end

   // quotient truncates toward zero, remainder follows the dividend sign
   // a zero divisor leaves quo all ones and rem equal to the dividend
   assign div_result.lo = neg_q ? -quo : quo;
   assign div_result.hi = neg_r ? -rem[`MD_XLEN-1:0] : rem[`MD_XLEN-1:0];

   assign div_done = fix;
   assign div_busy = busy || fix;

endmodule

//--- sim.f
+incdir+common
common/muldiv_pkg.sv
muldiv/muldiv_unit.sv
muldiv/radix2_divider.sv
hw/hilo_regs.sv
hw/exe_muldiv_top.sv
verification/tb_clock_gen.sv
verification/muldiv_assertions.sv
verification/muldiv_tb.sv

//--- verification/muldiv_assertions.sv
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module muldiv_assertions (
   input logic                   aclk,
   input logic                   rst,
   input muldiv_pkg::md_state_t  state,
   input logic                   stall,
   input logic                   finish,
   input logic                   div_start,
   input logic                   div_done
);

   import muldiv_pkg::*;

   int assert_fails = 0;   // failed assertions so far

   // divider answers exactly MD_DIV_ITER+1 cycles after the start pulse
   done_after_start: assert property (@(posedge aclk) disable iff (!rst)
      div_start |-> ##(`MD_DIV_ITER + 1) div_done)
      else begin
         assert_fails = assert_fails + 1;
         $error("div_done missing MD_DIV_ITER+1 cycles after div_start");
      end

   // pipeline released with finish in the cycle the divider reports done
   no_stall_at_done: assert property (@(posedge aclk) disable iff (!rst)
      div_done |-> (state == WAIT) && !stall && finish)
      else begin
         assert_fails = assert_fails + 1;
         $error("div_done outside WAIT, or stall still high, or no finish");
      end

   // one done pulse, so one finish per divide
   single_div_finish: assert property (@(posedge aclk) disable iff (!rst)
      div_done |=> !div_done)
      else begin
         assert_fails = assert_fails + 1;
         $error("div_done high for two cycles in a divide");
      end

endmodule

bind muldiv_unit muldiv_assertions u_assert (
   .aclk      (aclk),
   .rst       (rst),
   .state     (state),
   .stall     (stall),
   .finish    (finish),
   .div_start (div_start),
   .div_done  (div_done)
);

//--- verification/muldiv_tb.sv
`timescale 1ns/1ps
`include "muldiv_defines.svh"

module muldiv_tb;

   import muldiv_pkg::*;

   localparam int FINISH_TIMEOUT = 100;
   localparam int DIV_LATENCY    = `MD_DIV_ITER + 2;   // cycles from op to finish

   logic                aclk;
   logic                rst;
   alu_op_t             alu_op;
   logic [`MD_XLEN-1:0] operand_a;
   logic [`MD_XLEN-1:0] operand_b;
   logic                stall;
   logic                finish;
   logic [`MD_XLEN-1:0] hilo_rdata;
   logic [31:0]         lfsr_state = 32'he027_6c1c;

   tb_clock_gen u_clk (
      .aclk (aclk),
      .rst  (rst)
   );

   exe_muldiv_top DUT (
      .aclk       (aclk),
      .rst        (rst),
      .alu_op     (alu_op),
      .operand_a  (operand_a),
      .operand_b  (operand_b),
      .stall      (stall),
      .finish     (finish),
      .hilo_rdata (hilo_rdata)
   );

   task automatic check_equal(input string name, input logic [63:0] actual,
                              input logic [63:0] expected);
      if (actual !== expected) begin
         $display("ERROR at %0t: %s = %h, expected %h", $time, name, actual, expected);
         $display("Testbench failed");
         $fatal(1);
      end
   endtask

   task automatic fail_run(input string what);
      $display("%0t: %s", $time, what);
      $display("Testbench failed");
      $fatal(1);
   endtask

   // bound checker counts its failures
   always @(DUT.u_unit.u_assert.assert_fails) begin
      if (DUT.u_unit.u_assert.assert_fails != 0) begin
         fail_run("a bound assertion on the muldiv unit failed");
      end
   end

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);   // galois form
   endfunction

   // one lfsr step per bit taken
   task automatic rand_bits(input int n, output logic [31:0] w);
      w = '0;
      repeat (n) begin
         lfsr_state = lfsr_step(lfsr_state);
         w = {w[30:0], lfsr_state[0]};
      end
   endtask

   // present an operation a fixed delay after the edge
   task automatic issue_op(input alu_op_t op, input logic [31:0] a, input logic [31:0] b);
      @(posedge aclk);
      #2ns;
      alu_op    = op;
      operand_a = a;
      operand_b = b;
   endtask

   task automatic read_back(input logic [31:0] exp_hi, input logic [31:0] exp_lo);
      issue_op(`MD_OP_MFHI, '0, '0);
      @(negedge aclk);
      check_equal("hilo_rdata (MFHI)", hilo_rdata, exp_hi);
      issue_op(`MD_OP_MFLO, '0, '0);
      @(negedge aclk);
      check_equal("hilo_rdata (MFLO)", hilo_rdata, exp_lo);
      issue_op(`MD_OP_NOP, '0, '0);
   endtask

   task automatic run_mul(input alu_op_t op, input logic [31:0] a, input logic [31:0] b);
      logic signed [63:0] sa;
      logic signed [63:0] sb;
      logic [63:0]        expected;
      if (op == `MD_OP_MULT) begin
         sa = {{32{a[31]}}, a};
         sb = {{32{b[31]}}, b};
         expected = sa * sb;
      end else begin
         expected = {32'h0, a} * {32'h0, b};
      end
      issue_op(op, a, b);
      @(negedge aclk);
      check_equal("finish", finish, 1'b1);
      check_equal("stall", stall, 1'b0);
      read_back(expected[63:32], expected[31:0]);
   endtask

   // peek_cycle >= 2 swaps in an MFHI for one stalled cycle
   // read_result off leaves the next cycle free for another op
   task automatic run_div(input alu_op_t op, input logic [31:0] a, input logic [31:0] b,
                          input int peek_cycle, input logic [31:0] peek_hi,
                          input bit read_result);
      int          n;
      int          sa;
      int          sb;
      logic [31:0] q;
      logic [31:0] r;
      if (op == `MD_OP_DIVU) begin
         if (b == 0) begin
            q = '1;
            r = a;
         end else begin
            q = a / b;
            r = a % b;
         end
      end else begin
         sa = a;
         sb = b;
         q  = sa / sb;   // truncates toward zero
         r  = sa % sb;
      end
      issue_op(op, a, b);
      n = 0;
      @(negedge aclk);
      while (!finish) begin
         check_equal("stall", stall, 1'b1);
         if (n == peek_cycle) begin
            check_equal("hilo_rdata (MFHI in stall)", hilo_rdata, peek_hi);
         end
         n++;
         if (n > FINISH_TIMEOUT) begin
            fail_run("timeout: no finish within 100 cycles of a divide");
         end
         issue_op((n == peek_cycle) ? alu_op_t'(`MD_OP_MFHI) : op, a, b);
         @(negedge aclk);
      end
      check_equal("stall", stall, 1'b0);
      check_equal("divide latency", n, DIV_LATENCY);
      if (read_result) begin
         read_back(r, q);
      end
   endtask

   task automatic after_reset();
      issue_op(`MD_OP_NOP, '0, '0);
      @(negedge aclk);
      check_equal("stall", stall, 1'b0);
      check_equal("finish", finish, 1'b0);
      read_back('0, '0);
   endtask

   task automatic move_roundtrip();
      logic [31:0] x;
      logic [31:0] y;
      rand_bits(32, x);
      rand_bits(32, y);
      issue_op(`MD_OP_MTHI, x, '0);
      read_back(x, '0);   // lo untouched
      issue_op(`MD_OP_MTLO, y, '0);
      read_back(x, y);
   endtask

   task automatic mult_cases();
      logic [31:0] corner [3];
      logic [31:0] a;
      logic [31:0] b;
      corner[0] = 32'h8000_0000;
      corner[1] = 32'hffff_ffff;
      corner[2] = 32'h0000_0001;
      foreach (corner[i]) begin
         foreach (corner[j]) begin
            run_mul(`MD_OP_MULT, corner[i], corner[j]);
            run_mul(`MD_OP_MULTU, corner[i], corner[j]);
         end
      end
      repeat (20) begin
         rand_bits(32, a);
         rand_bits(32, b);
         run_mul(`MD_OP_MULT, a, b);
         run_mul(`MD_OP_MULTU, a, b);
      end
   endtask

   task automatic div_cases();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] sh;
      run_div(`MD_OP_DIV, 32'd100, 32'd7, -1, '0, 1'b1);
      run_div(`MD_OP_DIV, -32'sd100, 32'd7, -1, '0, 1'b1);
      run_div(`MD_OP_DIV, 32'd100, -32'sd7, -1, '0, 1'b1);
      run_div(`MD_OP_DIV, -32'sd100, -32'sd7, -1, '0, 1'b1);
      repeat (8) begin
         rand_bits(32, a);
         rand_bits(32, b);
         rand_bits(5, sh);
         b = b >> sh;   // spread the quotient sizes
         if (b == 0) begin
            b = 32'd3;
         end
         run_div(`MD_OP_DIVU, a, b, -1, '0, 1'b1);
         if (b == 32'hffff_ffff && a == 32'h8000_0000) begin
            b = 32'd5;   // no overflow case
         end
         run_div(`MD_OP_DIV, a, b, -1, '0, 1'b1);
      end
   endtask

   task automatic divu_by_zero();
      logic [31:0] a;
      rand_bits(32, a);
      run_div(`MD_OP_DIVU, a, '0, -1, '0, 1'b1);
   endtask

   task automatic div_then_mult();
      logic [31:0] x;
      logic [31:0] a;
      logic [31:0] b;
      rand_bits(32, x);
      rand_bits(32, a);
      rand_bits(16, b);
      issue_op(`MD_OP_MTHI, x, '0);
      run_div(`MD_OP_DIVU, a, b, 10, x, 1'b1);   // old hi visible while stalled
      issue_op(`MD_OP_NOP, '0, '0);
      rand_bits(32, x);
      rand_bits(32, b);
      run_div(`MD_OP_DIVU, a, b | 32'h1, -1, '0, 1'b0);
      // mult follows directly, no idle cycle
      run_mul(`MD_OP_MULT, x, b);
   endtask

   initial begin
      int n;
      alu_op    = `MD_OP_NOP;
      operand_a = '0;
      operand_b = '0;
      n = 0;
      while (rst !== 1'b1) begin
         @(posedge aclk);
         n++;
         if (n > FINISH_TIMEOUT) begin
            fail_run("reset was never released");
         end
      end
      after_reset();
      move_roundtrip();
      mult_cases();
      div_cases();
      divu_by_zero();
      div_then_mult();
      repeat (2) @(posedge aclk);
      @(negedge aclk);   // last sampled edge fully evaluated
      $display("Testbench passed");
      $finish;
   end

endmodule

//--- verification/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
   output logic aclk,
   output logic rst
);

   localparam time HALF_PERIOD = 20ns;   // 40 ns clock
   localparam int  RST_CYCLES  = 16;

   initial begin
      aclk = 1'b0;
      forever #HALF_PERIOD aclk = ~aclk;
   end

   initial begin
      rst = 1'b0;
      repeat (RST_CYCLES) @(posedge aclk);
      #2ns rst = 1'b1;   // release away from the edge
   end

endmodule
